// ==== verilog/addPkg.sv ====
`default_nettype none

package addPkg;

  ///////////////////////////////
  // Widths
  ///////////////////////////////
  localparam int dataWidth   = 16;  // Operand and result width
  localparam int nibbleWidth = 4;   // One lookahead group
  localparam int numNibbles  = 4;   // Groups per word

  ///////////////////////////////
  // Vector types
  ///////////////////////////////
  typedef logic [dataWidth-1:0]   word_t;         // Data word
  typedef logic [nibbleWidth-1:0] nibble_t;       // One nibble of a word
  typedef logic [numNibbles-1:0]  nibbleFlags_t;  // One flag per nibble

  // Clamp values for signed saturation
  localparam word_t   wordMax   = 16'h7FFF;  // Largest signed word
  localparam word_t   wordMin   = 16'h8000;  // Smallest signed word
  localparam nibble_t nibbleMax = 4'h7;      // Largest signed nibble
  localparam nibble_t nibbleMin = 4'h8;      // Smallest signed nibble

  // Operation select
  typedef enum logic [1:0] {
    opAdd    = 2'd0,  // Word add, saturated
    opSub    = 2'd1,  // Word subtract, saturated
    opPaddsb = 2'd2   // Four nibble adds, each saturated
  } op_t;

  // Handshake FSM states
  typedef enum logic [1:0] {idleIn, ackHigh, waitOpen} intakeState_t;
  typedef enum logic [1:0] {empty, reqHigh, waitAckLow} outputState_t;

endpackage

`default_nettype wire

// ==== verilog/claNibble.sv ====
`default_nettype none
`timescale 1ns/100ps

module claNibble (
  input  wire addPkg::nibble_t a,    // First operand nibble
  input  wire addPkg::nibble_t b,    // Second operand nibble
  input  wire                  cin,  // Carry from the lookahead level
  input  wire                  sub,  // Subtract this nibble
  output addPkg::nibble_t      sum,
  output logic                 cout,
  output logic                 posOvfl,  // Two positives gave a negative
  output logic                 negOvfl,  // Two negatives gave a positive
  output logic                 pGroup,   // Group propagate
  output logic                 gGroup    // Group generate
);

  addPkg::nibble_t bOp;    // b or its complement
  logic            cinOp;  // Effective carry-in
  addPkg::nibble_t p;      // Bit propagate
  addPkg::nibble_t g;      // Bit generate
  addPkg::nibble_t c;      // Carry out of each bit

  // Two's complement subtract is a + ~b + 1
  assign bOp   = sub ? ~b : b;
  assign cinOp = sub ? 1'b1 : cin;

  assign p = a | bOp;  // OR form is enough for carries
  assign g = a & bOp;

  ///////////////////////////////
  // Carry chain
  ///////////////////////////////
  assign c[0] = g[0] | (p[0] & cinOp);
  assign c[1] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cinOp);
  assign c[2] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
              | (p[2] & p[1] & p[0] & cinOp);
  assign c[3] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
              | (p[3] & p[2] & p[1] & g[0])
              | (p[3] & p[2] & p[1] & p[0] & cinOp);

  // Sum bits from the incoming carries
  assign sum[0] = a[0] ^ bOp[0] ^ cinOp;
  assign sum[1] = a[1] ^ bOp[1] ^ c[0];
  assign sum[2] = a[2] ^ bOp[2] ^ c[1];
  assign sum[3] = a[3] ^ bOp[3] ^ c[2];

  assign cout = c[3];

  ///////////////////////////////
  // Signed overflow
  ///////////////////////////////
  // Operand signs agree, result sign differs
  assign posOvfl = ~a[3] & ~bOp[3] &  sum[3];
  assign negOvfl =  a[3] &  bOp[3] & ~sum[3];

  // Group terms for the second level, independent of cin
  assign pGroup = &p;
  assign gGroup = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                | (p[3] & p[2] & p[1] & g[0]);

endmodule

`default_nettype wire

// ==== verilog/claAdder16.sv ====
`default_nettype none
`timescale 1ns/100ps

module claAdder16 (
  input  wire addPkg::word_t  a,
  input  wire addPkg::word_t  b,
  input  wire                 sub,           // Word or per-nibble subtract
  input  wire                 splitNibbles,  // Cut carries at nibble edges
  output addPkg::word_t       sum,
  output addPkg::nibbleFlags_t posOvfl,      // Per nibble, positive overflow
  output addPkg::nibbleFlags_t negOvfl       // Per nibble, negative overflow
);

  addPkg::nibbleFlags_t pGrp;   // Group propagate from each nibble
  addPkg::nibbleFlags_t gGrp;   // Group generate from each nibble
  addPkg::nibbleFlags_t carry;  // Lookahead carry into each nibble
  addPkg::nibbleFlags_t nibCin; // Carry actually given to each nibble

  ///////////////////////////////
  // Second-level lookahead
  ///////////////////////////////
  assign carry[0] = sub;  // Word carry-in, the +1 of a subtract
  assign carry[1] = gGrp[0] | (pGrp[0] & carry[0]);
  assign carry[2] = gGrp[1] | (pGrp[1] & gGrp[0])
                  | (pGrp[1] & pGrp[0] & carry[0]);
  assign carry[3] = gGrp[2] | (pGrp[2] & gGrp[1])
                  | (pGrp[2] & pGrp[1] & gGrp[0])
                  | (pGrp[2] & pGrp[1] & pGrp[0] & carry[0]);

  // No carry crosses a nibble boundary in split mode
  assign nibCin = splitNibbles ? '0 : carry;

  ///////////////////////////////
  // Nibble slices
  ///////////////////////////////
  for (genvar k = 0; k < addPkg::numNibbles; k++) begin : gNib
    logic            nibSub;  // Nibble does its own complement and +1
    addPkg::nibble_t bNib;    // b slice, complemented here for upper word nibbles

    // Lowest nibble always owns the +1, all nibbles do in split mode
    assign nibSub = sub & (splitNibbles | (k == 0));
    // Upper nibbles of a word subtract take ~b and the lookahead carry
    assign bNib = b[k*addPkg::nibbleWidth +: addPkg::nibbleWidth]
                ^ {addPkg::nibbleWidth{sub & ~nibSub}};

    claNibble nib (
      .a       (a[k*addPkg::nibbleWidth +: addPkg::nibbleWidth]),
      .b       (bNib),
      .cin     (nibCin[k]),
      .sub     (nibSub),
      .sum     (sum[k*addPkg::nibbleWidth +: addPkg::nibbleWidth]),
      .cout    (),            // Carry comes from the lookahead instead
      .posOvfl (posOvfl[k]),
      .negOvfl (negOvfl[k]),
      .pGroup  (pGrp[k]),
      .gGroup  (gGrp[k])
    );
  end

endmodule

`default_nettype wire

// ==== verilog/saturator.sv ====
`default_nettype none
`timescale 1ns/100ps

module saturator (
  input  wire addPkg::op_t          op,
  input  wire addPkg::word_t        rawSum,   // Unclamped adder output
  input  wire addPkg::nibbleFlags_t posOvfl,
  input  wire addPkg::nibbleFlags_t negOvfl,
  output logic                      sub,          // Adder control
  output logic                      splitNibbles, // Adder control
  output addPkg::word_t             value,    // Clamped result
  output logic                      hit       // Some clamp applied
);

  ///////////////////////////////
  // Op decode
  ///////////////////////////////
  always_comb begin
    sub          = 1'b0;
    splitNibbles = 1'b0;
    case (op)
      addPkg::opSub:    sub = 1'b1;
      addPkg::opPaddsb: splitNibbles = 1'b1;
      default:          ;                      // Plain add, also unused code
    endcase
  end

  ///////////////////////////////
  // Clamp
  ///////////////////////////////
  always_comb begin
    value = rawSum;
    hit   = 1'b0;
    if (splitNibbles) begin
      // Each nibble on its own
      for (int n = 0; n < addPkg::numNibbles; n++) begin
        if (posOvfl[n]) begin
          value[n*addPkg::nibbleWidth +: addPkg::nibbleWidth] = addPkg::nibbleMax;
        end else if (negOvfl[n]) begin
          value[n*addPkg::nibbleWidth +: addPkg::nibbleWidth] = addPkg::nibbleMin;
        end
      end
      hit = |(posOvfl | negOvfl);
    end else begin
      // Word result, only the sign nibble tells
      if (posOvfl[addPkg::numNibbles-1]) begin
        value = addPkg::wordMax;
      end else if (negOvfl[addPkg::numNibbles-1]) begin
        value = addPkg::wordMin;
      end
      hit = posOvfl[addPkg::numNibbles-1] | negOvfl[addPkg::numNibbles-1];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/opIntake.sv ====
`default_nettype none
`timescale 1ns/100ps

module opIntake (
  input  wire                 clk,
  input  wire                 rstN,
  input  wire                 inReq,     // Four-phase request
  input  wire addPkg::op_t    inOp,
  input  wire addPkg::word_t  inA,
  input  wire addPkg::word_t  inB,
  input  wire                 slotTake,  // Output side took the slot
  output logic                inAck,
  output logic                slotFull,
  output addPkg::op_t         slotOp,
  output addPkg::word_t       slotA,
  output addPkg::word_t       slotB
);

  addPkg::intakeState_t state;
  logic                 capture;  // Load the slot this edge

  // Only from idle, and only into an empty slot
  assign capture = (state == addPkg::idleIn) && inReq && !slotFull;

  assign inAck = (state == addPkg::ackHigh);

  ///////////////////////////////
  // Handshake FSM and slot flag
  ///////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state    <= addPkg::idleIn;
      slotFull <= 1'b0;
    end else begin
      case (state)
        addPkg::idleIn: begin
          if (capture) state <= addPkg::ackHigh;
        end
        addPkg::ackHigh: begin
          // Drop ack once req is low
          if (!inReq) begin
            if (slotFull && !slotTake) state <= addPkg::waitOpen;
            else state <= addPkg::idleIn;
          end
        end
        addPkg::waitOpen: begin
          if (!slotFull || slotTake) state <= addPkg::idleIn;  // Slot frees up
        end
        default: state <= addPkg::idleIn;
      endcase

      if (capture) slotFull <= 1'b1;
      else if (slotTake) slotFull <= 1'b0;
    end
  end

  // Operand holding register
  always_ff @(posedge clk) begin
    if (capture) begin
      slotOp <= inOp;
      slotA  <= inA;
      slotB  <= inB;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/resultOutput.sv ====
`default_nettype none
`timescale 1ns/100ps

module resultOutput (
  input  wire                 clk,
  input  wire                 rstN,
  input  wire                 slotFull,  // Operation waiting upstream
  input  wire addPkg::word_t  value,     // Clamped result of the slot
  input  wire                 hit,       // Saturation of the slot
  input  wire                 outAck,
  output logic                slotTake,  // One-cycle take pulse
  output addPkg::word_t       outResult,
  output logic                outSat,
  output logic                outReq
);

  addPkg::outputState_t state;

  // Take exactly when the registers load
  assign slotTake = (state == addPkg::empty) && slotFull;

  assign outReq = (state == addPkg::reqHigh);

  ///////////////////////////////
  // Output handshake FSM
  ///////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= addPkg::empty;
    end else begin
      case (state)
        addPkg::empty: begin
          if (slotTake) state <= addPkg::reqHigh;
        end
        addPkg::reqHigh: begin
          if (outAck) state <= addPkg::waitAckLow;  // Req falls next
        end
        addPkg::waitAckLow: begin
          if (!outAck) state <= addPkg::empty;  // Phase four done
        end
        default: state <= addPkg::empty;
      endcase
    end
  end

  // Result and flag stay put until the next take
  always_ff @(posedge clk) begin
    if (slotTake) begin
      outResult <= value;
      outSat    <= hit;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/addSubUnit.sv ====
`default_nettype none
`timescale 1ns/100ps

module addSubUnit (
  input  wire                 clk,
  input  wire                 rstN,
  input  wire                 inReq,
  input  wire addPkg::op_t    inOp,
  input  wire addPkg::word_t  inA,
  input  wire addPkg::word_t  inB,
  output logic                inAck,
  output logic                outReq,
  output addPkg::word_t       outResult,
  output logic                outSat,
  input  wire                 outAck
);

  ///////////////////////////////
  // Slot and datapath wires
  ///////////////////////////////
  logic                 slotFull;
  logic                 slotTake;
  addPkg::op_t          slotOp;
  addPkg::word_t        slotA;
  addPkg::word_t        slotB;
  logic                 sub;           // Decoded from slotOp
  logic                 splitNibbles;  // Decoded from slotOp
  addPkg::word_t        rawSum;
  addPkg::nibbleFlags_t posOvfl;
  addPkg::nibbleFlags_t negOvfl;
  addPkg::word_t        satValue;
  logic                 satHit;

  // Input side
  opIntake intake (
    .clk      (clk),
    .rstN     (rstN),
    .inReq    (inReq),
    .inOp     (inOp),
    .inA      (inA),
    .inB      (inB),
    .slotTake (slotTake),
    .inAck    (inAck),
    .slotFull (slotFull),
    .slotOp   (slotOp),
    .slotA    (slotA),
    .slotB    (slotB)
  );

  // Combinational core between slot and output registers
  claAdder16 adder (
    .a            (slotA),
    .b            (slotB),
    .sub          (sub),
    .splitNibbles (splitNibbles),
    .sum          (rawSum),
    .posOvfl      (posOvfl),
    .negOvfl      (negOvfl)
  );

  saturator sat (
    .op           (slotOp),
    .rawSum       (rawSum),
    .posOvfl      (posOvfl),
    .negOvfl      (negOvfl),
    .sub          (sub),
    .splitNibbles (splitNibbles),
    .value        (satValue),
    .hit          (satHit)
  );

  // Output side
  resultOutput outStage (
    .clk       (clk),
    .rstN      (rstN),
    .slotFull  (slotFull),
    .value     (satValue),
    .hit       (satHit),
    .outAck    (outAck),
    .slotTake  (slotTake),
    .outResult (outResult),
    .outSat    (outSat),
    .outReq    (outReq)
  );

endmodule

`default_nettype wire

// ==== sim/addSubChecker.sv ====
`default_nettype none
`timescale 1ns/100ps

module addSubChecker (
  input  wire                clk,
  input  wire                rstN,
  input  wire                inReq,
  input  wire                inAck,
  input  wire                outReq,
  input  wire addPkg::word_t outResult,
  input  wire                outSat,
  input  wire                outAck,
  output int                 resultCount,  // outReq rises seen
  output int                 failCount,    // Tests with a wrong value
  output int                 errorCount    // Every problem reported
);

  localparam string vectorFile = "sim/addSubVectors.txt";
  localparam int    maxVecs    = 64;

  logic [15:0]   vecMem [0:5*maxVecs-1];
  int            numVecs;
  logic          prevInReq;
  logic          prevInAck;
  logic          prevOutReq;
  addPkg::word_t heldResult;  // Latched at the outReq rise
  logic          heldSat;

  initial begin
    resultCount = 0;
    failCount   = 0;
    errorCount  = 0;
    $readmemh(vectorFile, vecMem);
    numVecs = 0;
    while (numVecs < maxVecs && !$isunknown(vecMem[5*numVecs])) begin
      numVecs++;
    end
  end

  // Next expected line against the new result in input order
  task automatic checkResult();
    int idx;
    bit bad;
    idx        = resultCount;
    bad        = 1'b0;
    heldResult = outResult;
    heldSat    = outSat;
    resultCount++;
    if (idx >= numVecs) begin
      $display("Extra result 0x%h arrived with no vector left", outResult);
      errorCount++;
    end else begin
      if (outResult !== vecMem[5*idx+3]) begin
        $display("ERROR test %0d outResult got 0x%h expected 0x%h",
                 idx, outResult, vecMem[5*idx+3]);
        bad = 1'b1;
        errorCount++;
      end
      if (outSat !== vecMem[5*idx+4][0]) begin
        $display("ERROR test %0d outSat got 0x%h expected 0x%h",
                 idx, outSat, vecMem[5*idx+4][0]);
        bad = 1'b1;
        errorCount++;
      end
      if (bad) failCount++;
      $display("Test %0d op %0h a 0x%h b 0x%h result 0x%h sat %0b %s", idx, vecMem[5*idx],
               vecMem[5*idx+1], vecMem[5*idx+2], outResult, outSat, bad ? "failed" : "passed");
    end
  endtask

  ///////////////////////////////
  // Protocol watch at mid-cycle
  ///////////////////////////////
  always @(negedge clk) begin
    if (!rstN) begin
      if (inAck !== 1'b0) begin
        $display("ERROR inAck in reset got 0x%h expected 0x0", inAck);
        errorCount++;
      end
      if (outReq !== 1'b0) begin
        $display("ERROR outReq in reset got 0x%h expected 0x0", outReq);
        errorCount++;
      end
    end else begin
      if (inAck && !prevInAck && !inReq) begin  // Ack without a request
        $display("inAck rose while inReq was low");
        errorCount++;
      end
      if (!inAck && prevInAck && (inReq || prevInReq)) begin
        $display("inAck fell before inReq was dropped");
        errorCount++;
      end
      if (outReq && !prevOutReq) begin
        checkResult();
      end else if (outReq) begin
        // Data frozen while req is up
        if (outResult !== heldResult) begin
          $display("ERROR outResult changed under outReq, 0x%h held 0x%h", outResult, heldResult);
          errorCount++;
        end
        if (outSat !== heldSat) begin
          $display("ERROR outSat changed under outReq, 0x%h held 0x%h", outSat, heldSat);
          errorCount++;
        end
      end
      if (!outReq && prevOutReq && !outAck) begin
        $display("outReq fell before outAck was raised");
        errorCount++;
      end
    end
    prevInReq  = inReq;
    prevInAck  = inAck;
    prevOutReq = outReq;
  end

endmodule

`default_nettype wire

// ==== sim/addSubUnitTb.sv ====
`default_nettype none
`timescale 1ns/100ps

module addSubUnitTb;

  localparam string vectorFile = "sim/addSubVectors.txt";
  localparam int    maxVecs    = 64;
  localparam int    waitLimit  = 60;  // Cycles one wait may take
  localparam int    randSeed   = 73;

  logic          clk;
  logic          rstN;
  logic          inReq;
  addPkg::op_t   inOp;
  addPkg::word_t inA;
  addPkg::word_t inB;
  logic          inAck;
  logic          outReq;
  addPkg::word_t outResult;
  logic          outSat;
  logic          outAck;
  int            resultCount;  // Counts kept by the checker
  int            failCount;
  int            errorCount;
  int            numVecs;
  bit            timedOut;
  logic [15:0]   vecMem [0:5*maxVecs-1];  // Five words per line, op a b result sat

  addSubUnit uut (.*);
  addSubChecker scoreboard (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // Wait for inAck or outReq to reach a level, sampled mid-cycle
  task automatic waitHandshake(input bit onOutput, input logic level, input int idx);
    int   cycles;
    logic seen;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      seen = onOutput ? outReq : inAck;
    end while (seen !== level && cycles < waitLimit);
    if (seen !== level) begin
      $display("Timeout in test %0d, %s did not go %s within %0d cycles",
               idx, onOutput ? "outReq" : "inAck", level ? "high" : "low", waitLimit);
      timedOut = 1'b1;
    end
  endtask

  ///////////////////////////////
  // Four-phase input driver
  ///////////////////////////////
  task automatic driveAll();
    for (int i = 0; i < numVecs && !timedOut; i++) begin
      @(posedge clk);
      inOp <= addPkg::op_t'(vecMem[5*i][1:0]);  // Data a cycle ahead of req
      inA  <= vecMem[5*i+1];
      inB  <= vecMem[5*i+2];
      @(posedge clk);
      inReq <= 1'b1;
      waitHandshake(1'b0, 1'b1, i);
      if (!timedOut) begin
        @(posedge clk);
        inReq <= 1'b0;
        waitHandshake(1'b0, 1'b0, i);  // Both low, data free again
      end
    end
  endtask

  // Output side with random back-pressure
  task automatic ackAll();
    int ackDelay;
    for (int n = 0; n < numVecs && !timedOut; n++) begin
      waitHandshake(1'b1, 1'b1, n);
      if (!timedOut) begin
        ackDelay = $urandom % 6;  // 0 to 5 cycles
        repeat (ackDelay) @(posedge clk);
        @(posedge clk);
        outAck <= 1'b1;
        waitHandshake(1'b1, 1'b0, n);
        ackDelay = $urandom % 6;
        repeat (ackDelay) @(posedge clk);
        @(posedge clk);
        outAck <= 1'b0;
      end
    end
  endtask

  initial begin : mainFlow
    int cycles;
    int seedDump;
    rstN   <= 1'b0;
    inReq  <= 1'b0;
    inOp   <= addPkg::opAdd;
    inA    <= '0;
    inB    <= '0;
    outAck <= 1'b0;
    seedDump = $urandom(randSeed);
    $readmemh(vectorFile, vecMem);
    numVecs = 0;
    while (numVecs < maxVecs && !$isunknown(vecMem[5*numVecs])) begin
      numVecs++;
    end
    if (numVecs == 0) $display("No vectors loaded from %s", vectorFile);
    repeat (3) @(posedge clk);  // Reset for three cycles
    rstN <= 1'b1;
    fork
      driveAll();
      ackAll();
    join
    cycles = 0;
    while (resultCount < numVecs && cycles < waitLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (resultCount < numVecs) begin
      $display("Missing results, only %0d of %0d arrived", resultCount, numVecs);
      timedOut = 1'b1;
    end
    $display("Tests %0d of %0d checked, %0d passed, %0d failed, %0d errors",
             resultCount, numVecs, resultCount - failCount, failCount, errorCount);
    if (!timedOut && numVecs > 0 && resultCount == numVecs && errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/addPkg.sv
verilog/claNibble.sv
verilog/claAdder16.sv
verilog/saturator.sv
verilog/opIntake.sv
verilog/resultOutput.sv
verilog/addSubUnit.sv
sim/addSubChecker.sv
sim/addSubUnitTb.sv

// ==== sim/addSubVectors.txt ====
// Columns, all hex: op a b expectedResult expectedSat
// op 0 word add, 1 word subtract, 2 four saturated nibble adds
// Word add, in range
0 0001 0002 0003 0
0 1234 4321 5555 0
0 FFFF 0001 0000 0
0 8000 7FFF FFFF 0
0 FFF0 FFF0 FFE0 0
0 00FF 0001 0100 0
0 7FFE 0001 7FFF 0
// Word add, clamped
0 7FFF 0001 7FFF 1
0 4000 4000 7FFF 1
0 8000 FFFF 8000 1
0 9000 A000 8000 1
// Word subtract, in range
1 0005 0003 0002 0
1 0003 0005 FFFE 0
1 8000 8000 0000 0
1 1234 0234 1000 0
1 0000 7FFF 8001 0
1 FFFF 7FFF 8000 0
// Word subtract, clamped
1 0000 8000 7FFF 1
1 7FFF FFFF 7FFF 1
1 8000 0001 8000 1
1 C000 7000 8000 1
1 7FFF 8000 7FFF 1
// Nibble adds, no carry between nibbles
2 1234 1111 2345 0
2 FFFF 1111 0000 0
2 9AB6 F0E1 8A97 0
2 0000 0000 0000 0
2 7777 1111 7777 1
2 8888 FFFF 8888 1
2 7385 12F2 7587 1
2 4321 4321 7642 1
